// File: include/fx2_defs.svh
// fx2 loopback constants for endpoint select codes, strobe settle time, credits and register bank
`ifndef FX2_DEFS_SVH
`define FX2_DEFS_SVH

// fifo_adr codes as seen by the FX2 slave FIFO
`define EP2_ADR 2'b00 // host OUT endpoint, read side
`define EP6_ADR 2'b10 // host IN endpoint, write side

// idle ifclk cycles between an address change and the first strobe
`define ADR_SETTLE 2

// writer buffer depth, also the read engine's starting credit count
`define RX_CREDITS 2

// spi register bank size
`define NUM_REGS 8

// register whose inverse drives the leds
`define LED_REG 0

`endif

// File: rtl/fx2_pkg.sv
// fx2 fifo types shared by the read engine, the writer and the top level
`default_nettype none

package fx2_pkg;

	// word written to EP6, high byte from EP2 and led byte below it
	typedef struct packed {
		logic [7:0] high_byte; // bits 15:8 of fd
		logic [7:0] low_byte;  // bits 7:0 of fd
	} fifo_word_t;

	// slave fifo strobes, all active low, plus endpoint select
	typedef struct packed {
		logic       slrd;     // read strobe
		logic       sloe;     // output enable of the fx2 data bus
		logic       slwr;     // write strobe
		logic [1:0] fifo_adr; // endpoint select
	} fifo_ctrl_t;

	// one received high byte on its way to the writer
	// valid is a single cycle pulse, one credit spent per pulse
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_byte_t;

endpackage

`default_nettype wire

// File: rtl/spi_pkg.sv
// spi register bus types for the frame on the wire and the register commit bundle
`default_nettype none

package spi_pkg;

	// frame as shifted in, msb first, rw bit leads
	typedef struct packed {
		logic       rw;   // 1 reads, 0 writes
		logic [6:0] addr; // register index
		logic [7:0] data; // write payload, don't care on reads
	} spi_frame_t;

	localparam int frame_bits = $bits(spi_frame_t); // sck edges in a full frame
	localparam int head_bits = 8;                   // rw plus addr, miso starts after these

	// commit bundle, strobe for one cycle when the frame was a good write
	typedef struct packed {
		logic       strobe;
		logic [6:0] addr;
		logic [7:0] data;
	} reg_write_t;

endpackage

`default_nettype wire

// File: rtl/ep2_read_engine.sv
// ep2 read engine, pulls one word per transaction from the OUT endpoint and forwards its high byte
`default_nettype none
`include "fx2_defs.svh"

module ep2_read_engine (
	input  logic                ifclk,
	input  logic                rst_n,
	input  logic                flaga,      // EP2 has data
	input  logic [15:0]         fd_in,
	input  logic                bus_busy,   // writer owns the pins
	input  logic                credit_ret, // writer freed a buffer slot
	output fx2_pkg::fifo_ctrl_t rd_ctrl,
	output logic                bus_req,
	output fx2_pkg::rx_byte_t   rx
);

	localparam int cw = $clog2(`RX_CREDITS + 1);
	localparam logic [1:0] settle_last = 2'(`ADR_SETTLE - 1);

	typedef enum logic [1:0] {
		rd_idle,
		rd_settle, // sloe low, waiting before slrd
		rd_strobe, // slrd low this cycle
		rd_done    // rx.valid out, bus released
	} rd_state_t;

	rd_state_t     state;
	logic [1:0]    settle_cnt;
	logic [cw-1:0] credits;
	logic          sloe_q;
	logic          slrd_q;
	logic          rx_valid_q;
	logic [7:0]    rx_data_q;
	logic          start;

	// a slot must be free downstream before a word leaves EP2
	assign start = (state == rd_idle) && (credits != '0) && !bus_busy && flaga;

	// bus_req rises in the start cycle itself so the writer cannot start on the same edge
	assign bus_req = start || (state == rd_settle) || (state == rd_strobe);

	assign rd_ctrl = '{slrd: slrd_q, sloe: sloe_q, slwr: 1'b1, fifo_adr: `EP2_ADR};
	assign rx = '{valid: rx_valid_q, data: rx_data_q};

	// credit taken at start, given back by the writer after each EP6 write
	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			credits <= cw'(`RX_CREDITS);
		end else begin
			case ({start, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // both or none
			endcase
		end
	end

	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			state      <= rd_idle;
			settle_cnt <= '0;
			sloe_q     <= 1'b1;
			slrd_q     <= 1'b1;
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0; // single cycle pulse
			case (state)
				rd_idle: begin
					if (start) begin
						sloe_q     <= 1'b0; // fx2 drives fd from here on
						settle_cnt <= '0;
						state      <= rd_settle;
					end
				end
				rd_settle: begin
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == settle_last) begin
						slrd_q <= 1'b0;
						state  <= rd_strobe;
					end
				end
				rd_strobe: begin
					slrd_q     <= 1'b1;
					sloe_q     <= 1'b1;
					rx_valid_q <= 1'b1;
					state      <= rd_done;
				end
				default: state <= rd_idle; // rd_done, one quiet cycle for the writer
			endcase
		end
	end

	// high byte taken on the edge that pops the fx2 fifo
	always_ff @(posedge ifclk) begin
		if (state == rd_strobe)
			rx_data_q <= fd_in[15:8];
	end

	a_slrd_with_sloe: assert property (@(posedge ifclk) disable iff (!rst_n)
		!rd_ctrl.slrd |-> !rd_ctrl.sloe);

	// credit_ret never comes back more often than credits went out
	a_credit_range: assert property (@(posedge ifclk) disable iff (!rst_n)
		credits <= cw'(`RX_CREDITS));

endmodule

`default_nettype wire

// File: rtl/spi_reg_bank.sv
// spi register bank, oversampled slave with eight read/write registers, register 0 drives the leds
`default_nettype none
`include "fx2_defs.svh"

module spi_reg_bank (
	input  logic       ifclk,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       mosi,
	input  logic       cs_n,
	output logic       miso,
	output logic [7:0] leds // active low pins
);

	localparam int aw = $clog2(`NUM_REGS);

	logic [1:0]          sck_sync;  // two-flop synchronisers
	logic [1:0]          mosi_sync;
	logic [1:0]          cs_sync;
	logic                sck_d;
	logic                cs_d;
	logic                sck_rise;
	logic                sck_fall;
	logic                cs_rise;
	logic                cs_fall;
	logic [15:0]         shift_q;
	logic [4:0]          bit_cnt;
	logic [7:0]          tx_q;
	logic [7:0]          rd_data;
	logic [7:0]          regs [`NUM_REGS];
	spi_pkg::spi_frame_t frame;
	spi_pkg::spi_frame_t head;  // first byte only, valid once 8 bits are in
	spi_pkg::reg_write_t wr_q;

	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			sck_sync <= '0;
			cs_sync  <= 2'b11; // deselected
			sck_d    <= 1'b0;
			cs_d     <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			cs_sync  <= {cs_sync[0], cs_n};
			sck_d    <= sck_sync[1];
			cs_d     <= cs_sync[1];
		end
	end

	// same delay as sck so data lines up with the detected edge
	always_ff @(posedge ifclk) mosi_sync <= {mosi_sync[0], mosi};

	assign sck_rise = sck_sync[1] & ~sck_d;
	assign sck_fall = ~sck_sync[1] & sck_d;
	assign cs_rise  = cs_sync[1] & ~cs_d;
	assign cs_fall  = ~cs_sync[1] & cs_d;

	assign frame = shift_q;
	assign head  = {shift_q[7:0], 8'h00};

	// bit counter saturates so an overlong frame never looks like 16 again
	always_ff @(posedge ifclk) begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (cs_fall)
			bit_cnt <= '0;
		else if (sck_rise && !cs_sync[1] && bit_cnt != 5'h1f)
			bit_cnt <= bit_cnt + 1'b1;
	end

	always_ff @(posedge ifclk) begin
		if (sck_rise && !cs_sync[1])
			shift_q <= {shift_q[14:0], mosi_sync[1]}; // msb first
	end

	// first edge after cs_n rises, latch the write, second edge commits it
	always_ff @(posedge ifclk) begin
		wr_q.addr <= frame.addr;
		wr_q.data <= frame.data;
		if (!rst_n)
			wr_q.strobe <= 1'b0;
		else
			wr_q.strobe <= cs_rise && (bit_cnt == 5'(spi_pkg::frame_bits)) && !frame.rw;
	end

	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_q.strobe && wr_q.addr < `NUM_REGS) begin
			regs[wr_q.addr[aw-1:0]] <= wr_q.data; // out of range writes dropped
		end
	end

	assign rd_data = (head.addr < `NUM_REGS) ? regs[head.addr[aw-1:0]] : 8'h00;

	// readback loads after the 8th falling edge, then shifts on each fall up to bit 15
	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			tx_q <= '0;
		end else if (cs_sync[1]) begin
			tx_q <= '0; // miso idles low between frames
		end else if (sck_fall) begin
			if (bit_cnt == 5'(spi_pkg::head_bits))
				tx_q <= head.rw ? rd_data : 8'h00;
			else if (bit_cnt < 5'(spi_pkg::frame_bits))
				tx_q <= {tx_q[6:0], 1'b0};
		end
	end

	assign miso = tx_q[7];
	assign leds = ~regs[`LED_REG]; // pins sink current

	// commit pipeline must only ever fire after the frame has closed
	a_commit_deselected: assert property (@(posedge ifclk) disable iff (!rst_n)
		wr_q.strobe |-> cs_sync[1] && cs_d);

endmodule

`default_nettype wire

// File: rtl/ep6_loopback_writer.sv
// ep6 loopback writer, buffers received bytes, pairs them with the led byte and owns the fifo pins
`default_nettype none
`include "fx2_defs.svh"

module ep6_loopback_writer (
	input  logic                ifclk,
	input  logic                rst_n,
	input  fx2_pkg::rx_byte_t   rx,
	input  logic [7:0]          leds,
	input  fx2_pkg::fifo_ctrl_t rd_ctrl,
	input  logic                bus_req,    // read engine wants or holds the bus
	input  logic                flagc,      // EP6 has room
	output logic                credit_ret,
	output logic                bus_busy,
	output fx2_pkg::fifo_ctrl_t fifo_ctrl,
	output fx2_pkg::fifo_word_t fd_out,
	output logic                fd_oe
);

	localparam int cw = $clog2(`RX_CREDITS + 1);
	localparam int pw = $clog2(`RX_CREDITS);
	localparam logic [1:0] settle_last = 2'(`ADR_SETTLE - 1);

	typedef enum logic [1:0] {
		wr_idle,
		wr_settle, // EP6 selected, data on the bus
		wr_strobe  // slwr low this cycle
	} wr_state_t;

	wr_state_t           state;
	logic [1:0]          settle_cnt;
	logic [7:0]          buf_mem [`RX_CREDITS]; // byte fifo
	logic [pw-1:0]       wr_ptr;
	logic [pw-1:0]       rd_ptr;
	logic [cw-1:0]       count;
	logic                slwr_q;
	logic                start;
	logic                pop;
	fx2_pkg::fifo_ctrl_t wr_ctrl;

	assign start = (state == wr_idle) && (count != '0) && !bus_req && flagc;
	assign pop   = (state == wr_strobe); // entry freed once the word is in EP6

	always_ff @(posedge ifclk) begin
		if (rx.valid)
			buf_mem[wr_ptr] <= rx.data;
	end

	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (rx.valid)
				wr_ptr <= (wr_ptr == pw'(`RX_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == pw'(`RX_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cw'(rx.valid) - cw'(pop);
		end
	end

	always_ff @(posedge ifclk) begin
		if (!rst_n) begin
			state      <= wr_idle;
			settle_cnt <= '0;
			slwr_q     <= 1'b1;
			credit_ret <= 1'b0;
		end else begin
			credit_ret <= 1'b0;
			case (state)
				wr_idle: begin
					if (start) begin
						settle_cnt <= '0;
						state      <= wr_settle;
					end
				end
				wr_settle: begin
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == settle_last) begin
						slwr_q <= 1'b0;
						state  <= wr_strobe;
					end
				end
				default: begin // wr_strobe
					slwr_q     <= 1'b1;
					credit_ret <= 1'b1; // read engine may fetch one more
					state      <= wr_idle;
				end
			endcase
		end
	end

	// word built once per write, led byte as it stands at the start
	always_ff @(posedge ifclk) begin
		if (start)
			fd_out <= '{high_byte: buf_mem[rd_ptr], low_byte: leds};
	end

	assign bus_busy = (state != wr_idle);
	assign fd_oe    = bus_busy; // fpga drives fd for the whole write
	assign wr_ctrl  = '{slrd: 1'b1, sloe: 1'b1, slwr: slwr_q, fifo_adr: `EP6_ADR};

	// read side passes through while idle, adr falls back to EP2 with it
	assign fifo_ctrl = bus_busy ? wr_ctrl : rd_ctrl;

	a_slwr_driven: assert property (@(posedge ifclk) disable iff (!rst_n)
		!fifo_ctrl.slwr |-> fd_oe && fifo_ctrl.fifo_adr == `EP6_ADR);

	// read engine credits must keep pushes within the buffer
	a_no_overflow: assert property (@(posedge ifclk) disable iff (!rst_n)
		rx.valid |-> (count < cw'(`RX_CREDITS)) || pop);

endmodule

`default_nettype wire

// File: rtl/fx2_led_loopback.sv
// fx2 led loopback top, EP2 high bytes return on EP6 with the led byte below them
`default_nettype none

module fx2_led_loopback (
	input  logic        ifclk,
	input  logic        rst_n,
	input  logic        flaga,    // EP2 not empty
	input  logic        flagc,    // EP6 not full
	input  logic [15:0] fd_in,
	output logic [15:0] fd_out,
	output logic        fd_oe,    // pad tristate enable, handled by the board wrapper
	output logic        slrd,
	output logic        sloe,
	output logic        slwr,
	output logic [1:0]  fifo_adr,
	input  logic        sck,
	input  logic        mosi,
	output logic        miso,
	input  logic        cs_n,
	output logic [7:0]  leds
);

	fx2_pkg::fifo_ctrl_t rd_ctrl;   // read engine strobes
	fx2_pkg::fifo_ctrl_t fifo_ctrl; // what reaches the pins
	fx2_pkg::rx_byte_t   rx;
	fx2_pkg::fifo_word_t tx_word;
	logic                bus_req;
	logic                bus_busy;
	logic                credit_ret;

	ep2_read_engine u_read (
		.ifclk      (ifclk),
		.rst_n      (rst_n),
		.flaga      (flaga),
		.fd_in      (fd_in),
		.bus_busy   (bus_busy),
		.credit_ret (credit_ret),
		.rd_ctrl    (rd_ctrl),
		.bus_req    (bus_req),
		.rx         (rx)
	);

	spi_reg_bank u_regs (
		.ifclk (ifclk),
		.rst_n (rst_n),
		.sck   (sck),
		.mosi  (mosi),
		.cs_n  (cs_n),
		.miso  (miso),
		.leds  (leds)
	);

	ep6_loopback_writer u_write (
		.ifclk      (ifclk),
		.rst_n      (rst_n),
		.rx         (rx),
		.leds       (leds),     // low byte of every EP6 word
		.rd_ctrl    (rd_ctrl),
		.bus_req    (bus_req),
		.flagc      (flagc),
		.credit_ret (credit_ret),
		.bus_busy   (bus_busy),
		.fifo_ctrl  (fifo_ctrl),
		.fd_out     (tx_word),
		.fd_oe      (fd_oe)
	);

	assign fd_out   = tx_word;
	assign slrd     = fifo_ctrl.slrd;
	assign sloe     = fifo_ctrl.sloe;
	assign slwr     = fifo_ctrl.slwr;
	assign fifo_adr = fifo_ctrl.fifo_adr;

endmodule

`default_nettype wire

// File: testbench/tb_fx2_led_loopback.sv
// testbench for the fx2 led loopback, with fifo endpoint model, spi master and record driven checks
`default_nettype none
`include "fx2_defs.svh"

module tb_fx2_led_loopback;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int spi_half = 5; // ifclk cycles per sck phase, well above the synchroniser delay

	logic        ifclk;
	logic        rst_n;
	logic        flaga;
	logic        flagc;
	logic [15:0] fd_in;
	logic [15:0] fd_out;
	logic        fd_oe;
	logic        slrd;
	logic        sloe;
	logic        slwr;
	logic [1:0]  fifo_adr;
	logic        sck;
	logic        mosi;
	logic        miso;
	logic        cs_n;
	logic [7:0]  leds;

	logic [15:0] ep2_q[$];  // host OUT endpoint contents
	logic [15:0] exp_q[$];  // EP6 words still due, oldest first
	byte         rec_op[$];
	logic [15:0] rec_a[$];
	logic [15:0] rec_b[$];
	logic [7:0]  reg_model [`NUM_REGS];
	int          value_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;
	int          full_cnt = 0;  // EP6 full cycles left
	int          full_run = 0;  // negedges in a row with flagc low
	int          pops = 0;
	int          ep6_words = 0;
	bit          pop_due = 1'b0;
	bit          checking = 1'b0;
	logic        slrd_prev = 1'b1;
	logic        slwr_prev = 1'b1;

	fx2_led_loopback DUT (.*);

	initial ifclk = 1'b0;
	always #10 ifclk = ~ifclk;

	// run limit comes from the record count
	always @(posedge ifclk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles with %0d EP6 words outstanding",
				cycles, exp_q.size());
			$display("errors: %0d value, %0d other", value_errs, other_errs + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// fx2 side of the fifo, updated just after each edge
	always @(posedge ifclk) begin
		#2;
		if (pop_due) begin
			if (ep2_q.size() != 0)
				void'(ep2_q.pop_front()); // word left EP2 on the slrd edge
			pop_due = 1'b0;
		end
		flagc = (full_cnt == 0);
		if (full_cnt > 0)
			full_cnt = full_cnt - 1;
		flaga = (fifo_adr == `EP2_ADR) && (ep2_q.size() != 0);
		fd_in = (!sloe && ep2_q.size() != 0) ? ep2_q[0] : 16'h0000; // fx2 drives only under sloe
	end

	// strobe rules and EP6 capture, pins are stable at the falling edge
	always @(negedge ifclk) begin
		if (checking) begin
			full_run = flagc ? 0 : full_run + 1;
			if (!slrd) begin
				if (sloe || fifo_adr != `EP2_ADR) begin
					$display("slrd low without sloe low and EP2 selected at %0t", $time);
					other_errs++;
				end
				if (ep2_q.size() == 0) begin
					$display("EP2 read while the endpoint is empty at %0t", $time);
					other_errs++;
				end
				pops++;
				pop_due = 1'b1;
			end
			if (!slwr) begin
				if (!fd_oe || fifo_adr != `EP6_ADR) begin
					$display("slwr low without fd_oe high and EP6 selected at %0t", $time);
					other_errs++;
				end
				if (full_run >= 4) begin // a write needs flagc high three edges before slwr
					$display("EP6 write while the endpoint is full at %0t", $time);
					other_errs++;
				end
				ep6_words++;
				if (exp_q.size() == 0) begin
					$display("EP6 word 0x%h arrived with none expected at %0t", fd_out, $time);
					other_errs++;
				end else begin
					if (fd_out !== exp_q[0]) begin
						$display("Error: fd_out expected 0x%h got 0x%h", exp_q[0], fd_out);
						value_errs++;
					end
					void'(exp_q.pop_front());
				end
			end
			if (!slrd && !slrd_prev) begin
				$display("slrd held low longer than one cycle at %0t", $time);
				other_errs++;
			end
			if (!slwr && !slwr_prev) begin
				$display("slwr held low longer than one cycle at %0t", $time);
				other_errs++;
			end
			if (pops - ep6_words > `RX_CREDITS) begin
				$display("more words popped from EP2 than the credits allow at %0t", $time);
				other_errs++;
			end
		end
		slrd_prev = slrd;
		slwr_prev = slwr;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge ifclk);
		#2;
	endtask

	// midway between edges, away from every other tb action
	task automatic wait_mid_cycle();
		@(negedge ifclk);
		#5;
	endtask

	// one pin against its idle level
	task automatic check_pin(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error: %s expected 0x%h got 0x%h", name, exp, got);
			value_errs++;
		end
	endtask

	// one 16 bit frame, msb first, readback sampled before each rising sck
	task automatic spi_transfer(input logic [15:0] frame, output logic [7:0] rdata);
		rdata = 8'h00;
		wait_cycles(1);
		cs_n = 1'b0;
		wait_cycles(spi_half);
		for (int i = 15; i >= 0; i--) begin
			mosi = frame[i];
			wait_cycles(spi_half);
			if (i < 8)
				rdata[i] = miso;
			sck = 1'b1;
			wait_cycles(spi_half);
			sck = 1'b0;
		end
		wait_cycles(spi_half);
		cs_n = 1'b1;
		wait_cycles(4 * spi_half); // commit lands a few cycles after cs_n rises
	endtask

	initial begin
		int          fd;
		int          n;
		string       tok;
		string       rest;
		logic [15:0] a;
		logic [15:0] b;
		logic [7:0]  rdata;

		rst_n = 1'b0;
		flaga = 1'b0;
		flagc = 1'b1;
		fd_in = 16'h0000;
		sck   = 1'b0;
		mosi  = 1'b0;
		cs_n  = 1'b1;
		for (int i = 0; i < `NUM_REGS; i++)
			reg_model[i] = 8'h00;

		fd = $fopen("testbench/fx2_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/fx2_testdata.txt");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tok);
				if (n != 1)
					break;
				if (tok.getc(0) == "#") begin
					n = $fgets(rest, fd); // comment line
				end else begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n != 2) begin
						$display("malformed record starting with %s", tok);
						other_errs++;
					end
					rec_op.push_back(tok.getc(0));
					rec_a.push_back(a);
					rec_b.push_back(b);
				end
			end
			$fclose(fd);
		end
		cycle_limit = 1000 + 200 * rec_op.size();

		wait_cycles(5);
		rst_n = 1'b1;
		checking = 1'b1;
		if (leds !== 8'hff) begin
			$display("Error: leds expected 0x%h got 0x%h", 8'hff, leds);
			value_errs++;
		end
		check_pin("slrd", 8'(slrd), 8'h01);
		check_pin("sloe", 8'(sloe), 8'h01);
		check_pin("slwr", 8'(slwr), 8'h01);
		check_pin("fd_oe", 8'(fd_oe), 8'h00);
		check_pin("fifo_adr", 8'(fifo_adr), 8'(`EP2_ADR));

		for (int r = 0; r < rec_op.size(); r++) begin
			case (rec_op[r])
				"S": begin
					spi_transfer({1'b0, rec_a[r][6:0], rec_b[r][7:0]}, rdata);
					if (rec_a[r] < `NUM_REGS)
						reg_model[rec_a[r]] = rec_b[r][7:0]; // higher addresses are dropped
					if (leds !== ~reg_model[`LED_REG]) begin
						$display("Error: leds expected 0x%h got 0x%h", ~reg_model[`LED_REG], leds);
						value_errs++;
					end
				end
				"R": begin
					spi_transfer({1'b1, rec_a[r][6:0], 8'h00}, rdata);
					if (rdata !== rec_b[r][7:0]) begin
						$display("Error: miso reg %0d expected 0x%h got 0x%h",
							rec_a[r], rec_b[r][7:0], rdata);
						value_errs++;
					end
				end
				"W": begin
					wait_mid_cycle();
					ep2_q.push_back(rec_a[r]);
					exp_q.push_back({rec_a[r][15:8], ~reg_model[`LED_REG]}); // led byte below
				end
				"F": begin
					wait_mid_cycle();
					full_cnt = rec_a[r];
				end
				"D": begin
					while (exp_q.size() != 0)
						wait_cycles(1);
				end
				default: begin
					$display("unknown record type in the data file");
					other_errs++;
				end
			endcase
		end

		wait_cycles(10);
		if (exp_q.size() != 0 || ep2_q.size() != 0) begin
			$display("words left over at the end of the run");
			other_errs++;
		end
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/fx2_testdata.txt
# op a b, hex fields: S spi write addr data, R spi read addr expected, W ep2 word
# F ep6 full for a cycles, D wait for all EP6 words, unused fields are 0
R 00 00
S 00 5a
R 00 5a
S 03 c3
S 07 81
S 08 ee
R 00 5a
S 09 ff
R 01 00
R 03 c3
W 12ab 0000
W 3400 0000
W fe01 0000
W 0f0f 0000
D 0000 0000
S 00 0f
R 00 0f
F 0028 0000
W 5566 0000
W 7788 0000
W 99aa 0000
W bbcc 0000
W ddee 0000
D 0000 0000
S 00 f0
W a1b2 0000
W c3d4 0000
F 0010 0000
W e5f6 0000
D 0000 0000
R 07 81

// File: fx2_led_loopback.f
+incdir+include
rtl/fx2_pkg.sv
rtl/spi_pkg.sv
rtl/ep2_read_engine.sv
rtl/spi_reg_bank.sv
rtl/ep6_loopback_writer.sv
rtl/fx2_led_loopback.sv
testbench/tb_fx2_led_loopback.sv

// File: Makefile
# Verilator build and run for the fx2 led loopback testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_fx2_led_loopback
FILELIST  ?= fx2_led_loopback.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) include/fx2_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
